// File: cps_video_defines.svh
// ******************************
// Raster sizes, pixel and palette widths,
// register map and pipeline timing
// ******************************
`ifndef CPS_VIDEO_DEFINES_SVH
`define CPS_VIDEO_DEFINES_SVH

// Raster geometry, in pixels and lines
`define CPS_H_TOTAL         512
`define CPS_H_ACTIVE        384
`define CPS_HS_START        416
`define CPS_HS_END          448
`define CPS_V_TOTAL         262
`define CPS_V_ACTIVE        224
`define CPS_VS_START        236
`define CPS_VS_END          240
`define CPS_CNT_W           9

// Layer pixel layout is {palette select, pen}
`define CPS_PEN_W           4
`define CPS_PALSEL_W        5
`define CPS_LAYER_PXL_W     9
`define CPS_PEN_CLEAR       15

// Palette RAM word address
`define CPS_PAL_ADDR_W      12

// CPU register map, word addresses
`define CPS_REG_ADDR_W      5
`define CPS_REG_LAYER_CTRL  5'd0
`define CPS_REG_RASTER      5'd1

// Pixel steps from mixer input to RGB output
`define CPS_BLNK_DLY        3

`endif

// File: cps_video_pkg.sv
// ******************************
// Mixed pixel union and layer codes
// ******************************
`include "cps_video_defines.svh"

package cps_video_pkg;

    // Layer id takes what is left of the palette address
    localparam int LAYER_W = `CPS_PAL_ADDR_W - `CPS_PALSEL_W - `CPS_PEN_W;

    typedef struct packed {
        logic [LAYER_W-1:0]       layer;
        logic [`CPS_PALSEL_W-1:0] pal;
        logic [`CPS_PEN_W-1:0]    pen;
    } mix_fields_t;

    // Mixer writes the fields, palette reads the flat address
    typedef union packed {
        logic [`CPS_PAL_ADDR_W-1:0] addr;
        mix_fields_t                fields;
    } mix_pixel_t;

    // Layer codes as stored in the layer id field
    localparam logic [LAYER_W-1:0] LAYER_OBJ  = 3'd0;
    localparam logic [LAYER_W-1:0] LAYER_SCR1 = 3'd1;
    localparam logic [LAYER_W-1:0] LAYER_SCR2 = 3'd2;
    localparam logic [LAYER_W-1:0] LAYER_SCR3 = 3'd3;
    localparam logic [LAYER_W-1:0] LAYER_BACK = 3'd7;

endpackage

// File: cps_timing.sv
// ******************************
// Raster counters, blanking, syncs
// and line/frame strobes
// ******************************
`timescale 1ns/1ps
`include "cps_video_defines.svh"

module cps_timing (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pxl_cen,
    output logic [`CPS_CNT_W-1:0] hdump,
    output logic [`CPS_CNT_W-1:0] vdump,
    output logic                  HB,
    output logic                  VB,
    output logic                  HS,
    output logic                  VS,
    output logic                  line_start,
    output logic                  frame_start
);

    logic [`CPS_CNT_W-1:0] hnext;
    logic [`CPS_CNT_W-1:0] vnext;
    logic                  hwrap;

    // Next counter values, decoded ahead so every output moves together
    always_comb begin
        hwrap = hdump == `CPS_CNT_W'(`CPS_H_TOTAL - 1);
        hnext = hwrap ? '0 : hdump + 1'b1;
        if (!hwrap) begin
            vnext = vdump;
        end else if (vdump == `CPS_CNT_W'(`CPS_V_TOTAL - 1)) begin
            vnext = '0;
        end else begin
            vnext = vdump + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump       <= '0;
            vdump       <= '0;
            HB          <= 1'b0;
            VB          <= 1'b0;
            HS          <= 1'b0;
            VS          <= 1'b0;
            line_start  <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            // Strobes last a single clk
            line_start  <= 1'b0;
            frame_start <= 1'b0;
            if (pxl_cen) begin
                hdump <= hnext;
                vdump <= vnext;
                HB    <= hnext >= `CPS_CNT_W'(`CPS_H_ACTIVE);
                VB    <= vnext >= `CPS_CNT_W'(`CPS_V_ACTIVE);
                HS    <= hnext >= `CPS_CNT_W'(`CPS_HS_START) &&
                         hnext <  `CPS_CNT_W'(`CPS_HS_END);
                VS    <= vnext >= `CPS_CNT_W'(`CPS_VS_START) &&
                         vnext <  `CPS_CNT_W'(`CPS_VS_END);
                line_start  <= hnext == '0;
                frame_start <= hnext == '0 && vnext == '0;
            end
        end
    end

endmodule

// File: cps_mmr.sv
// ******************************
// CPU register file and
// raster line interrupt
// ******************************
`timescale 1ns/1ps
`include "cps_video_defines.svh"

module cps_mmr (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       ppu_cs,
    input  logic [`CPS_REG_ADDR_W-1:0] addr,
    input  logic [1:0]                 dsn,
    input  logic [15:0]                cpu_dout,
    output logic [15:0]                mmr_dout,
    input  logic                       line_start,
    input  logic                       frame_start,
    input  logic [`CPS_CNT_W-1:0]      vdump,
    output logic [15:0]                layer_ctrl,
    output logic                       raster
);

    logic [15:0]           raster_line;
    logic [`CPS_CNT_W-1:0] cur_line;

    // dsn is active low, one bit per byte lane
    function automatic logic [15:0] lane_merge(
        input logic [15:0] old_val,
        input logic [15:0] new_val,
        input logic [1:0]  lanes_n
    );
        logic [15:0] res;
        res = old_val;
        if (!lanes_n[1]) begin
            res[15:8] = new_val[15:8];
        end
        if (!lanes_n[0]) begin
            res[7:0] = new_val[7:0];
        end
        return res;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            layer_ctrl  <= '0;
            raster_line <= '0;
        end else if (ppu_cs) begin
            case (addr)
                `CPS_REG_LAYER_CTRL: layer_ctrl  <= lane_merge(layer_ctrl, cpu_dout, dsn);
                `CPS_REG_RASTER:     raster_line <= lane_merge(raster_line, cpu_dout, dsn);
                default: ;
            endcase
        end
    end

    // Readback, zero for unmapped addresses
    always_comb begin
        case (addr)
            `CPS_REG_LAYER_CTRL: mmr_dout = layer_ctrl;
            `CPS_REG_RASTER:     mmr_dout = raster_line;
            default:             mmr_dout = '0;
        endcase
    end

    // Line that line_start has just opened
    assign cur_line = frame_start ? '0 : vdump;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            raster <= 1'b0;
        end else begin
            raster <= line_start && raster_line == 16'(cur_line);
        end
    end

endmodule

// File: cps_layer_mix.sv
// ******************************
// Four-layer priority mixer
// ******************************
`timescale 1ns/1ps
`include "cps_video_defines.svh"

module cps_layer_mix (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pxl_cen,
    input  logic [15:0]                  layer_ctrl,
    input  logic [`CPS_LAYER_PXL_W-1:0]  obj_pxl,
    input  logic [`CPS_LAYER_PXL_W-1:0]  scr1_pxl,
    input  logic [`CPS_LAYER_PXL_W-1:0]  scr2_pxl,
    input  logic [`CPS_LAYER_PXL_W-1:0]  scr3_pxl,
    output cps_video_pkg::mix_pixel_t    mix_pxl
);

    logic [`CPS_LAYER_PXL_W-1:0] layer_pxl [4];
    logic [3:0]                  layer_en;
    cps_video_pkg::mix_pixel_t   next_pxl;

    // 2-bit slot code to layer id
    function automatic logic [cps_video_pkg::LAYER_W-1:0] code_to_layer(
        input logic [1:0] code
    );
        case (code)
            2'd0:    return cps_video_pkg::LAYER_OBJ;
            2'd1:    return cps_video_pkg::LAYER_SCR1;
            2'd2:    return cps_video_pkg::LAYER_SCR2;
            default: return cps_video_pkg::LAYER_SCR3;
        endcase
    endfunction

    // Indexed by slot code
    assign layer_pxl[0] = obj_pxl;
    assign layer_pxl[1] = scr1_pxl;
    assign layer_pxl[2] = scr2_pxl;
    assign layer_pxl[3] = scr3_pxl;
    assign layer_en     = {layer_ctrl[3:1], layer_ctrl[4]};

    always_comb begin
        logic [1:0]                  code;
        logic [`CPS_LAYER_PXL_W-1:0] pix;
        // Backdrop unless a slot below overrides it
        next_pxl.fields.layer = cps_video_pkg::LAYER_BACK;
        next_pxl.fields.pal   = '1;
        next_pxl.fields.pen   = `CPS_PEN_W'(`CPS_PEN_CLEAR);
        // Walk from lowest priority up, so slot 0 wins last
        for (int s = 3; s >= 0; s--) begin
            code = layer_ctrl[6 + 2*s +: 2];
            pix  = layer_pxl[code];
            if (layer_en[code] && pix[`CPS_PEN_W-1:0] != `CPS_PEN_W'(`CPS_PEN_CLEAR)) begin
                next_pxl.fields.layer = code_to_layer(code);
                next_pxl.fields.pal   = pix[`CPS_LAYER_PXL_W-1 -: `CPS_PALSEL_W];
                next_pxl.fields.pen   = pix[`CPS_PEN_W-1:0];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mix_pxl.addr <= '1;
        end else if (pxl_cen) begin
            mix_pxl <= next_pxl;
        end
    end

endmodule

// File: cps_palette.sv
// ******************************
// Palette RAM, brightness scaler
// and blanking delay
// ******************************
`timescale 1ns/1ps
`include "cps_video_defines.svh"

module cps_palette (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        pxl_cen,
    input  logic                        pal_cs,
    input  logic [`CPS_PAL_ADDR_W-1:0]  pal_addr,
    input  logic [1:0]                  dsn,
    input  logic [15:0]                 cpu_dout,
    input  cps_video_pkg::mix_pixel_t   mix_pxl,
    input  logic                        HB,
    input  logic                        VB,
    output logic [7:0]                  red,
    output logic [7:0]                  green,
    output logic [7:0]                  blue,
    output logic                        LHBL_dly,
    output logic                        LVBL_dly
);

    logic [15:0]              pal_ram [0:(1 << `CPS_PAL_ADDR_W) - 1];
    logic [15:0]              pal_word;
    logic [`CPS_BLNK_DLY-1:0] lhbl_sr;
    logic [`CPS_BLNK_DLY-1:0] lvbl_sr;
    logic                     blank;

    // c * (b + 16) / 2, fits in 8 bits for 4-bit inputs
    function automatic logic [7:0] scale(
        input logic [3:0] c,
        input logic [3:0] b
    );
        logic [8:0] prod;
        prod = 9'(c) * (9'd16 + 9'(b));
        return prod[8:1];
    endfunction

    // CPU write port with byte lanes
    always_ff @(posedge clk) begin
        if (pal_cs && !dsn[1]) begin
            pal_ram[pal_addr][15:8] <= cpu_dout[15:8];
        end
        if (pal_cs && !dsn[0]) begin
            pal_ram[pal_addr][7:0] <= cpu_dout[7:0];
        end
    end

    // Pixel read port
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pal_word <= pal_ram[mix_pxl.addr];
        end
    end

    // Blank value that moves into the last delay stage this step
    assign blank    = !(lhbl_sr[`CPS_BLNK_DLY-2] && lvbl_sr[`CPS_BLNK_DLY-2]);
    assign LHBL_dly = lhbl_sr[`CPS_BLNK_DLY-1];
    assign LVBL_dly = lvbl_sr[`CPS_BLNK_DLY-1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lhbl_sr <= '1;
            lvbl_sr <= '1;
            red     <= '0;
            green   <= '0;
            blue    <= '0;
        end else if (pxl_cen) begin
            lhbl_sr <= {lhbl_sr[`CPS_BLNK_DLY-2:0], ~HB};
            lvbl_sr <= {lvbl_sr[`CPS_BLNK_DLY-2:0], ~VB};
            if (blank) begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end else begin
                red   <= scale(pal_word[11:8], pal_word[15:12]);
                green <= scale(pal_word[7:4], pal_word[15:12]);
                blue  <= scale(pal_word[3:0], pal_word[15:12]);
            end
        end
    end

endmodule

// File: cps_video.sv
// ******************************
// Video back end top level
// ******************************
`timescale 1ns/1ps
`include "cps_video_defines.svh"

module cps_video (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pxl_cen,
    // CPU side
    input  logic                         ppu_cs,
    input  logic                         pal_cs,
    input  logic [13:1]                  addr,
    input  logic [1:0]                   dsn,
    input  logic [15:0]                  cpu_dout,
    output logic [15:0]                  mmr_dout,
    // Layer pixels
    input  logic [`CPS_LAYER_PXL_W-1:0]  obj_pxl,
    input  logic [`CPS_LAYER_PXL_W-1:0]  scr1_pxl,
    input  logic [`CPS_LAYER_PXL_W-1:0]  scr2_pxl,
    input  logic [`CPS_LAYER_PXL_W-1:0]  scr3_pxl,
    // Raster
    output logic [`CPS_CNT_W-1:0]        hdump,
    output logic [`CPS_CNT_W-1:0]        vdump,
    output logic                         HS,
    output logic                         VS,
    output logic                         HB,
    output logic                         VB,
    output logic                         raster,
    // Video out
    output logic [7:0]                   red,
    output logic [7:0]                   green,
    output logic [7:0]                   blue,
    output logic                         LHBL_dly,
    output logic                         LVBL_dly
);

    logic                      line_start;
    logic                      frame_start;
    logic [15:0]               layer_ctrl;
    cps_video_pkg::mix_pixel_t mix_pxl;

    cps_timing u_timing (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen),
        .hdump(hdump), .vdump(vdump),
        .HB(HB), .VB(VB), .HS(HS), .VS(VS),
        .line_start(line_start), .frame_start(frame_start)
    );

    cps_mmr u_mmr (
        .clk(clk), .rst(rst),
        .ppu_cs(ppu_cs), .addr(addr[5:1]), .dsn(dsn),
        .cpu_dout(cpu_dout), .mmr_dout(mmr_dout),
        .line_start(line_start), .frame_start(frame_start), .vdump(vdump),
        .layer_ctrl(layer_ctrl), .raster(raster)
    );

    cps_layer_mix u_mix (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen),
        .layer_ctrl(layer_ctrl),
        .obj_pxl(obj_pxl), .scr1_pxl(scr1_pxl),
        .scr2_pxl(scr2_pxl), .scr3_pxl(scr3_pxl),
        .mix_pxl(mix_pxl)
    );

    // Palette is word addressed by the CPU
    cps_palette u_pal (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen),
        .pal_cs(pal_cs), .pal_addr(addr[12:1]), .dsn(dsn), .cpu_dout(cpu_dout),
        .mix_pxl(mix_pxl), .HB(HB), .VB(VB),
        .red(red), .green(green), .blue(blue),
        .LHBL_dly(LHBL_dly), .LVBL_dly(LVBL_dly)
    );

endmodule

// File: tb_cps_video.sv
// ******************************
// Testbench for the video back end
// ******************************
`timescale 1ns/1ps
`include "cps_video_defines.svh"

module tb_cps_video;

    localparam int STREAM_STEPS = 2 * `CPS_H_TOTAL * `CPS_V_TOTAL + 16;
    localparam int RASTER_LINE  = 100;
    localparam longint TIMEOUT_NS = (2 * STREAM_STEPS + 3 * 4096 + 2000) * 10;

    logic clk, rst, pxl_cen, ppu_cs, pal_cs;
    logic [13:1] addr;
    logic [1:0] dsn;
    logic [15:0] cpu_dout, mmr_dout;
    logic [8:0] obj_pxl, scr1_pxl, scr2_pxl, scr3_pxl, hdump, vdump;
    logic HS, VS, HB, VB, raster, LHBL_dly, LVBL_dly;
    logic [7:0] red, green, blue;

    // Model state
    logic [31:0] rng;
    logic [15:0] pal_shadow [0:4095];
    logic [15:0] ctrl_shadow, raster_shadow, exp_mmr;
    logic [25:0] exp_q [$];
    logic [25:0] exp_out;
    logic rgb_valid, streaming, exp_raster, raster_pending;
    int h_exp, v_exp, errors, test_base, n_tests, n_failed, raster_hits;

    cps_video cps_video_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [15:0] lane_update(input logic [15:0] old_v, new_v,
                                                input logic [1:0] lanes_n);
        return {lanes_n[1] ? old_v[15:8] : new_v[15:8], lanes_n[0] ? old_v[7:0] : new_v[7:0]};
    endfunction

    // First opaque enabled slot in priority order, then palette lookup and brightness
    function automatic logic [25:0] expected_pixel(input logic [15:0] ctrl,
                                                   input logic [8:0] px0, px1, px2, px3,
                                                   input logic hb, vb);
        logic [8:0] px [4];
        logic [3:0] en;
        logic [1:0] code;
        logic found;
        logic [11:0] pa;
        logic [15:0] w;
        logic [7:0] r, g, b;
        px = '{px0, px1, px2, px3};
        // Enable bits: object at 4, scroll 1 to 3 at 1 to 3
        en[0] = ctrl[4];
        en[1] = ctrl[1];
        en[2] = ctrl[2];
        en[3] = ctrl[3];
        pa = 12'hfff;
        found = 1'b0;
        for (int s = 0; s < 4; s++) begin
            code = ctrl[6 + 2*s +: 2];
            if (!found && en[code] && px[code][3:0] != 4'd15) begin
                pa = {1'b0, code, px[code]};
                found = 1'b1;
            end
        end
        w = pal_shadow[pa];
        r = 8'((w[11:8] * (w[15:12] + 16)) / 2);
        g = 8'((w[7:4] * (w[15:12] + 16)) / 2);
        b = 8'((w[3:0] * (w[15:12] + 16)) / 2);
        if (hb || vb) {r, g, b} = '0;
        return {~hb, ~vb, r, g, b};
    endfunction

    always_comb begin
        case (addr[5:1])
            5'd0:    exp_mmr = ctrl_shadow;
            5'd1:    exp_mmr = raster_shadow;
            default: exp_mmr = '0;
        endcase
    end

    // Reset state holds until pixels start flowing
    assert property (@(posedge clk) (rst || !streaming) |->
                     (red == 0 && green == 0 && blue == 0 && !raster && LHBL_dly && LVBL_dly))
        else begin
            errors++;
            $display("FAIL %0t rgb/raster/LHBL_dly/LVBL_dly exp=%h/%b/%b got=%h/%b/%b", $time,
                     24'h0, 1'b0, 2'b11, $sampled({red, green, blue}), $sampled(raster),
                     $sampled({LHBL_dly, LVBL_dly}));
        end
    assert property (@(posedge clk) disable iff (rst) hdump == h_exp && vdump == v_exp)
        else begin
            errors++;
            $display("FAIL %0t hdump/vdump exp=%0d/%0d got=%0d/%0d",
                     $time, h_exp, v_exp, $sampled(hdump), $sampled(vdump));
        end
    assert property (@(posedge clk) disable iff (rst)
                     HB == (hdump >= `CPS_H_ACTIVE) && VB == (vdump >= `CPS_V_ACTIVE))
        else begin
            errors++;
            $display("FAIL %0t HB/VB exp=%b%b got=%b%b", $time,
                     $sampled(hdump) >= `CPS_H_ACTIVE, $sampled(vdump) >= `CPS_V_ACTIVE,
                     $sampled(HB), $sampled(VB));
        end
    assert property (@(posedge clk) disable iff (rst)
                     HS == (hdump >= `CPS_HS_START && hdump < `CPS_HS_END) &&
                     VS == (vdump >= `CPS_VS_START && vdump < `CPS_VS_END))
        else begin
            errors++;
            $display("FAIL %0t HS/VS exp=%b%b got=%b%b", $time,
                     $sampled(hdump) >= `CPS_HS_START && $sampled(hdump) < `CPS_HS_END,
                     $sampled(vdump) >= `CPS_VS_START && $sampled(vdump) < `CPS_VS_END,
                     $sampled(HS), $sampled(VS));
        end
    assert property (@(posedge clk) disable iff (rst) !ppu_cs && !pal_cs |-> mmr_dout == exp_mmr)
        else begin
            errors++;
            $display("FAIL %0t mmr_dout exp=%h got=%h", $time,
                     $sampled(exp_mmr), $sampled(mmr_dout));
        end
    assert property (@(posedge clk) disable iff (rst || !streaming) raster == exp_raster)
        else begin
            errors++;
            $display("FAIL %0t raster exp=%b got=%b", $time,
                     $sampled(exp_raster), $sampled(raster));
        end
    assert property (@(posedge clk) disable iff (rst)
                     rgb_valid |-> {red, green, blue} == exp_out[23:0])
        else begin
            errors++;
            $display("FAIL %0t rgb exp=%h got=%h", $time,
                     $sampled(exp_out[23:0]), $sampled({red, green, blue}));
        end
    assert property (@(posedge clk) disable iff (rst)
                     rgb_valid |-> {LHBL_dly, LVBL_dly} == exp_out[25:24])
        else begin
            errors++;
            $display("FAIL %0t LHBL_dly/LVBL_dly exp=%b got=%b", $time,
                     $sampled(exp_out[25:24]), $sampled({LHBL_dly, LVBL_dly}));
        end

    always @(posedge clk) begin
        if (!rst && raster) raster_hits++;
    end

    task automatic reg_write(input logic [4:0] a, input logic [1:0] lanes_n, input logic [15:0] d);
        @(negedge clk);
        ppu_cs = 1'b1;
        addr = {8'd0, a};
        dsn = lanes_n;
        cpu_dout = d;
        @(negedge clk);
        ppu_cs = 1'b0;
        dsn = 2'b11;
        if (a == 5'd0) ctrl_shadow = lane_update(ctrl_shadow, d, lanes_n);
        if (a == 5'd1) raster_shadow = lane_update(raster_shadow, d, lanes_n);
        @(negedge clk);
    endtask

    task automatic pal_write(input logic [11:0] a, input logic [1:0] lanes_n, input logic [15:0] d);
        @(negedge clk);
        pal_cs = 1'b1;
        addr = {1'b0, a};
        dsn = lanes_n;
        cpu_dout = d;
        @(negedge clk);
        pal_cs = 1'b0;
        dsn = 2'b11;
        pal_shadow[a] = lane_update(pal_shadow[a], d, lanes_n);
    endtask

    task automatic end_test(input string name);
        n_tests++;
        if (errors != test_base) n_failed++;
        $display("test %s: %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    // Watchdog sized from reset, palette load and two streamed frames
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout, the run did not finish in time");
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [8:0] px [4];
        rng = 32'he258f18e;
        {rst, pxl_cen, ppu_cs, pal_cs, streaming, rgb_valid} = 6'b100000;
        {exp_raster, raster_pending, exp_out} = '0;
        {addr, dsn, cpu_dout} = {13'd0, 2'b11, 16'd0};
        {obj_pxl, scr1_pxl, scr2_pxl, scr3_pxl} = '0;
        {ctrl_shadow, raster_shadow} = '0;
        {h_exp, v_exp, errors, test_base, n_tests, n_failed, raster_hits} = '0;
        repeat (16) @(posedge clk);
        @(negedge clk) rst = 1'b0;
        repeat (4) @(negedge clk);
        end_test("reset");

        reg_write(5'd0, 2'b00, 16'h1234);
        reg_write(5'd0, 2'b01, 16'habcd);
        reg_write(5'd0, 2'b10, 16'h5a5a);
        reg_write(5'd1, 2'b00, 16'hffff);
        reg_write(5'd1, 2'b10, 16'h0000);
        reg_write(5'd9, 2'b00, 16'h7777);
        reg_write(5'd1, 2'b00, 16'(RASTER_LINE));
        end_test("registers");

        // Full words first, then some single byte lanes
        for (int a = 0; a < 4096; a++) begin
            r = next_random();
            pal_write(12'(a), 2'b00, r[15:0]);
        end
        for (int i = 0; i < 64; i++) begin
            r = next_random();
            pal_write(r[11:0], r[16] ? 2'b01 : 2'b10, r[31:16]);
        end
        r = next_random();
        reg_write(5'd0, 2'b00, r[15:0]);
        end_test("palette load");

        for (int i = 0; i < STREAM_STEPS; i++) begin
            @(negedge clk);
            ppu_cs = 1'b0;
            exp_raster = raster_pending;
            raster_pending = 1'b0;
            for (int l = 0; l < 4; l++) begin
                r = next_random();
                px[l] = r[4] ? {r[12:8], 4'd15} : r[8:0];
            end
            exp_q.push_back(expected_pixel(ctrl_shadow, px[0], px[1], px[2], px[3], HB, VB));
            {obj_pxl, scr1_pxl, scr2_pxl, scr3_pxl} = {px[0], px[1], px[2], px[3]};
            pxl_cen = 1'b1;
            streaming = 1'b1;
            @(negedge clk);
            pxl_cen = 1'b0;
            exp_raster = 1'b0;
            if (exp_q.size() == 3) begin
                exp_out = exp_q.pop_front();
                rgb_valid = 1'b1;
            end
            h_exp = (h_exp + 1) % `CPS_H_TOTAL;
            if (h_exp == 0) v_exp = (v_exp + 1) % `CPS_V_TOTAL;
            if (h_exp == 0 && v_exp == raster_shadow) raster_pending = 1'b1;
            if (i % 1024 == 1023) begin
                r = next_random();
                ppu_cs = 1'b1;
                addr = 13'd0;
                dsn = 2'b00;
                cpu_dout = r[15:0];
                ctrl_shadow = cpu_dout;
            end
        end
        // One pulse per frame over the two streamed frames
        assert (raster_hits == 2)
        else begin
            errors++;
            $display("FAIL %0t raster pulses exp=2 got=%0d", $time, raster_hits);
        end
        end_test("mixing, timing and raster");

        $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+.
cps_video_pkg.sv
cps_timing.sv
cps_mmr.sv
cps_layer_mix.sv
cps_palette.sv
cps_video.sv
tb_cps_video.sv

// File: run.sh
#!/bin/bash
# Build and run the testbench with Verilator, pass only on the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_cps_video \
    -o sim_tb_cps_video &&
    ./obj_dir/sim_tb_cps_video | tee /dev/stderr | grep -q "Test completed successfully" &&
    echo "PASS" ||
    { echo "FAIL"; exit 1; }
